//--- common/heapPkg.sv
/* Codes shared by the array heap RTL and its testbench.
   Action codes above actionAddAfter are answered with errorBadAction. */
`default_nettype none

package heapPkg;

  // ----------------------------------------
  // Commands from the caller
  // ----------------------------------------
  typedef enum logic [4:0] {
    actionIdle     = 5'd0,                      // No command this cycle
    actionReset    = 5'd1,                      // Forget all arrays
    actionWrite    = 5'd2,                      // Store element, may grow size
    actionRead     = 5'd3,                      // Fetch element
    actionSize     = 5'd4,                      // Current array size
    actionPush     = 5'd5,                      // Append at the end
    actionPop      = 5'd6,                      // Remove from the end
    actionAlloc    = 5'd7,                      // Hand out an array number
    actionFree     = 5'd8,                      // Return array for reuse
    actionAdd      = 5'd9,                      // Add, answer new value
    actionAddAfter = 5'd10                      // Add, answer old value
  } heapAction;

  // ----------------------------------------
  // Result codes
  // ----------------------------------------
  typedef enum logic [2:0] {
    errorNone         = 3'd0,
    errorNotAllocated = 3'd1,                   // Number never handed out
    errorFreed        = 3'd2,                   // Array was freed
    errorOutOfBounds  = 3'd3,                   // Index not below size
    errorFull         = 3'd4,                   // Push on full array
    errorEmpty        = 3'd5,                   // Pop on empty array
    errorOutOfMemory  = 3'd6,                   // No array left to allocate
    errorBadAction    = 3'd7                    // Unknown action code
  } heapError;

  // Operations sent from the decoder to one bank
  typedef enum logic [3:0] {
    opNop      = 4'd0,
    opClear    = 4'd1,                          // Size back to zero
    opWrite    = 4'd2,
    opRead     = 4'd3,
    opSize     = 4'd4,
    opPush     = 4'd5,
    opPop      = 4'd6,
    opAdd      = 4'd7,
    opAddAfter = 4'd8
  } bankOp;

endpackage

`default_nettype wire

//--- verilog/heapCommandDecoder.sv
/* Checks each action against the allocation state and steers it to one bank.
   Alloc answers with the array number, Free with the freed number and Reset
   with zero. Needs dataBits >= arrayBits. */
`default_nettype none

module heapCommandDecoder #(
  parameter int arrayBits = 3,
  parameter int indexBits = 3,
  parameter int dataBits  = 16
) (
  input  wire logic                   clock,
  input  wire logic                   resetN,
  input  wire heapPkg::heapAction     action,
  input  wire logic [arrayBits-1:0]   array,
  input  wire logic [indexBits-1:0]   index,
  input  wire logic [dataBits-1:0]    dataIn,
  output heapPkg::bankOp              op,          // Shared by all banks
  output logic [2**arrayBits-1:0]     bankSelect,  // One hot
  output logic [indexBits-1:0]        bankIndex,
  output logic [dataBits-1:0]         operand,
  output logic                        decodeDone,
  output heapPkg::heapError           decodeError,
  output logic [dataBits-1:0]         decodeData,
  output logic                        fromBank,
  output logic [arrayBits-1:0]        answerBank
);

  localparam int arrays = 2 ** arrayBits;

  logic [arrays-1:0]    allocated;                 // Handed out and live
  logic [arrays-1:0]    freedFlags;                // Freed since last handed out
  logic [arrayBits:0]   everAllocated;             // Arrays ever handed out
  logic [arrayBits-1:0] freeStack [arrays];        // Freed numbers, newest on top
  logic [arrayBits:0]   stackTop;                  // Entries in freeStack
  logic [arrayBits:0]   stackBelow;
  logic                 haveFreed;
  logic                 canGrow;
  logic [arrayBits-1:0] allocPick;                 // Number the next Alloc gets
  logic                 live;
  heapPkg::heapError    accessError;
  heapPkg::heapError    nextError;
  logic                 toBank;

  function automatic heapPkg::bankOp mapOp(input heapPkg::heapAction act);
    case (act)
      heapPkg::actionWrite:    return heapPkg::opWrite;
      heapPkg::actionRead:     return heapPkg::opRead;
      heapPkg::actionSize:     return heapPkg::opSize;
      heapPkg::actionPush:     return heapPkg::opPush;
      heapPkg::actionPop:      return heapPkg::opPop;
      heapPkg::actionAdd:      return heapPkg::opAdd;
      heapPkg::actionAddAfter: return heapPkg::opAddAfter;
      default:                 return heapPkg::opNop;   // Not a bank action
    endcase
  endfunction

  // ----------------------------------------
  // Allocation checks
  // ----------------------------------------
  assign stackBelow  = stackTop - 1'b1;
  assign haveFreed   = stackTop != '0;
  assign canGrow     = everAllocated != (arrayBits + 1)'(arrays);
  assign allocPick   = haveFreed ? freeStack[stackBelow[arrayBits-1:0]]
                                 : everAllocated[arrayBits-1:0];   // Reuse newest freed first
  assign live        = allocated[array];
  assign accessError = freedFlags[array] ? heapPkg::errorFreed : heapPkg::errorNotAllocated;
  assign bankIndex   = index;
  assign operand     = dataIn;

  always_comb begin
    op         = heapPkg::opNop;
    bankSelect = '0;
    toBank     = 1'b0;
    nextError  = heapPkg::errorNone;
    case (action)
      heapPkg::actionIdle, heapPkg::actionReset: ;
      heapPkg::actionAlloc: begin
        if (haveFreed || canGrow) begin
          op                    = heapPkg::opClear;   // New array starts empty
          bankSelect[allocPick] = 1'b1;
        end else begin
          nextError = heapPkg::errorOutOfMemory;
        end
      end
      heapPkg::actionFree: begin
        if (!live) nextError = accessError;         // Catches double free too
      end
      default: begin
        if (mapOp(action) == heapPkg::opNop) begin
          nextError = heapPkg::errorBadAction;
        end else if (!live) begin
          nextError = accessError;                  // Decoder error wins, no bank
        end else begin
          op                = mapOp(action);
          bankSelect[array] = 1'b1;
          toBank            = 1'b1;
        end
      end
    endcase
  end

  // ----------------------------------------
  // State and answer registers
  // ----------------------------------------
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      allocated     <= '0;
      freedFlags    <= '0;
      everAllocated <= '0;
      stackTop      <= '0;
      decodeDone    <= 1'b0;
      decodeError   <= heapPkg::errorNone;
      decodeData    <= '0;
      fromBank      <= 1'b0;
      answerBank    <= '0;
    end else begin
      decodeDone  <= action != heapPkg::actionIdle;
      decodeError <= nextError;
      fromBank    <= toBank;
      answerBank  <= array;
      case (action)
        heapPkg::actionReset: begin
          allocated     <= '0;
          freedFlags    <= '0;
          everAllocated <= '0;
          stackTop      <= '0;
          decodeData    <= '0;
        end
        heapPkg::actionAlloc: begin
          if (nextError == heapPkg::errorNone) begin
            allocated[allocPick]  <= 1'b1;
            freedFlags[allocPick] <= 1'b0;
            if (haveFreed) stackTop <= stackBelow;      // Pop freed number
            else everAllocated <= everAllocated + 1'b1;
            decodeData <= dataBits'(allocPick);
          end
        end
        heapPkg::actionFree: begin
          if (nextError == heapPkg::errorNone) begin
            allocated[array]  <= 1'b0;
            freedFlags[array] <= 1'b1;
            stackTop          <= stackTop + 1'b1;
            decodeData        <= dataBits'(array);
          end
        end
        default: ;
      endcase
    end
  end

  // Stack slots, top never passes arrays-1 on a push
  always_ff @(posedge clock) begin
    if (action == heapPkg::actionFree && nextError == heapPkg::errorNone) begin
      freeStack[stackTop[arrayBits-1:0]] <= array;
    end
  end

endmodule

`default_nettype wire

//--- arrayBank/arrayBank.sv
/* Storage of one array with its size counter. Acts only when selected.
   Elements never written read back unknown. Needs dataBits > indexBits. */
`default_nettype none

module arrayBank #(
  parameter int indexBits = 3,
  parameter int dataBits  = 16
) (
  input  wire logic                 clock,
  input  wire logic                 resetN,
  input  wire logic                 select,     // This bank is addressed
  input  wire heapPkg::bankOp       op,
  input  wire logic [indexBits-1:0] index,
  input  wire logic [dataBits-1:0]  operand,
  output logic [dataBits-1:0]       data,       // Answer for the last op
  output heapPkg::heapError         bankError
);

  localparam int arrayLength = 2 ** indexBits;

  logic [dataBits-1:0]  elements [arrayLength];
  logic [indexBits:0]   size;                     // Elements in use
  logic                 inBounds;                 // Index below size
  logic                 isFull;
  logic                 isEmpty;
  logic [indexBits-1:0] lastIndex;                // Top element for Pop
  logic [dataBits-1:0]  current;                  // Element at index
  logic [dataBits-1:0]  sum;                      // Wraps at dataBits

  assign inBounds  = {1'b0, index} < size;
  assign isFull    = size == (indexBits + 1)'(arrayLength);
  assign isEmpty   = size == '0;
  assign lastIndex = indexBits'(size - 1'b1);
  assign current   = elements[index];
  assign sum       = current + operand;

  // ----------------------------------------
  // Size and error
  // ----------------------------------------
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      size      <= '0;
      bankError <= heapPkg::errorNone;
    end else if (select) begin
      bankError <= heapPkg::errorNone;
      case (op)
        heapPkg::opClear: size <= '0;
        heapPkg::opWrite: begin
          if (!inBounds) size <= {1'b0, index} + 1'b1;   // Grow to cover index
        end
        heapPkg::opRead, heapPkg::opAdd, heapPkg::opAddAfter: begin
          if (!inBounds) bankError <= heapPkg::errorOutOfBounds;
        end
        heapPkg::opPush: begin
          if (isFull) bankError <= heapPkg::errorFull;
          else size <= size + 1'b1;
        end
        heapPkg::opPop: begin
          if (isEmpty) bankError <= heapPkg::errorEmpty;
          else size <= size - 1'b1;
        end
        default: ;
      endcase
    end
  end

  // ----------------------------------------
  // Elements and answer data
  // ----------------------------------------
  always_ff @(posedge clock) begin
    if (select) begin
      case (op)
        heapPkg::opWrite: begin
          elements[index] <= operand;
          data            <= operand;             // Echo written value
        end
        heapPkg::opRead: if (inBounds) data <= current;
        heapPkg::opSize: data <= dataBits'(size);
        heapPkg::opPush: begin
          if (!isFull) begin
            elements[size[indexBits-1:0]] <= operand;
            data                          <= operand;
          end
        end
        heapPkg::opPop: if (!isEmpty) data <= elements[lastIndex];
        heapPkg::opAdd: begin
          if (inBounds) begin
            elements[index] <= sum;
            data            <= sum;               // New value
          end
        end
        heapPkg::opAddAfter: begin
          if (inBounds) begin
            elements[index] <= sum;
            data            <= current;           // Previous value
          end
        end
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- verilog/resultCollector.sv
/* Forms the caller's answer in the cycle after the action. dataOut only
   changes on a done without error and holds otherwise. */
`default_nettype none

module resultCollector #(
  parameter int arrayBits = 3,
  parameter int dataBits  = 16
) (
  input  wire logic                                 clock,
  input  wire logic                                 resetN,
  input  wire logic                                 decodeDone,
  input  wire heapPkg::heapError                    decodeError,
  input  wire logic [dataBits-1:0]                  decodeData,
  input  wire logic                                 fromBank,
  input  wire logic [arrayBits-1:0]                 answerBank,
  input  wire logic [2**arrayBits-1:0][dataBits-1:0] bankData,
  input  wire heapPkg::heapError [2**arrayBits-1:0] bankError,
  output logic [dataBits-1:0]                       dataOut,
  output heapPkg::heapError                         error,
  output logic                                      done
);

  logic [dataBits-1:0] heldData;                  // Last answered value
  logic [dataBits-1:0] answerData;
  logic                load;                      // New data this cycle

  assign answerData = fromBank ? bankData[answerBank] : decodeData;
  assign error      = fromBank ? bankError[answerBank] : decodeError;
  assign done       = decodeDone;
  assign load       = decodeDone && error == heapPkg::errorNone;
  assign dataOut    = load ? answerData : heldData;

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) heldData <= '0;
    else heldData <= dataOut;
  end

endmodule

`default_nettype wire

//--- verilog/arrayHeap.sv
/* Heap of 2**arrayBits arrays of 2**indexBits elements. One action per clock,
   answer with done one cycle later, no back-pressure. */
`default_nettype none

module arrayHeap #(
  parameter int arrayBits = 3,
  parameter int indexBits = 3,
  parameter int dataBits  = 16
) (
  input  wire logic                 clock,
  input  wire logic                 resetN,
  input  wire heapPkg::heapAction   action,
  input  wire logic [arrayBits-1:0] array,
  input  wire logic [indexBits-1:0] index,
  input  wire logic [dataBits-1:0]  dataIn,
  output logic [dataBits-1:0]       dataOut,
  output heapPkg::heapError         error,
  output logic                      done
);

  localparam int arrays = 2 ** arrayBits;

  // ----------------------------------------
  // Decoder to banks and collector
  // ----------------------------------------
  heapPkg::bankOp                   op;
  logic [arrays-1:0]                bankSelect;
  logic [indexBits-1:0]             bankIndex;
  logic [dataBits-1:0]              operand;
  logic                             decodeDone;
  heapPkg::heapError                decodeError;
  logic [dataBits-1:0]              decodeData;
  logic                             fromBank;
  logic [arrayBits-1:0]             answerBank;
  logic [arrays-1:0][dataBits-1:0]  bankData;     // Packed per bank
  heapPkg::heapError [arrays-1:0]   bankError;

  heapCommandDecoder #(
    .arrayBits (arrayBits),
    .indexBits (indexBits),
    .dataBits  (dataBits)
  ) u_decoder (
    .clock       (clock),
    .resetN      (resetN),
    .action      (action),
    .array       (array),
    .index       (index),
    .dataIn      (dataIn),
    .op          (op),
    .bankSelect  (bankSelect),
    .bankIndex   (bankIndex),
    .operand     (operand),
    .decodeDone  (decodeDone),
    .decodeError (decodeError),
    .decodeData  (decodeData),
    .fromBank    (fromBank),
    .answerBank  (answerBank)
  );

  for (genvar n = 0; n < arrays; n++) begin : gBank
    arrayBank #(
      .indexBits (indexBits),
      .dataBits  (dataBits)
    ) u_bank (
      .clock     (clock),
      .resetN    (resetN),
      .select    (bankSelect[n]),
      .op        (op),
      .index     (bankIndex),
      .operand   (operand),
      .data      (bankData[n]),
      .bankError (bankError[n])
    );
  end

  resultCollector #(
    .arrayBits (arrayBits),
    .dataBits  (dataBits)
  ) u_collector (
    .clock       (clock),
    .resetN      (resetN),
    .decodeDone  (decodeDone),
    .decodeError (decodeError),
    .decodeData  (decodeData),
    .fromBank    (fromBank),
    .answerBank  (answerBank),
    .bankData    (bankData),
    .bankError   (bankError),
    .dataOut     (dataOut),
    .error       (error),
    .done        (done)
  );

endmodule

`default_nettype wire

//--- test/heapRefModel.svh
/* Expected answers of the array heap, built from its command rules.
   Included inside the testbench module. Reads of never written elements
   give X, so stimulus only reads elements it has stored. */
`ifndef HEAP_REF_MODEL_SVH
`define HEAP_REF_MODEL_SVH

bit                  mAllocated [arrays];              // Live arrays
bit                  mFreed [arrays];                  // Freed since last alloc
int                  mEver;                            // Numbers ever handed out
int                  mStack [$];                       // Freed numbers, newest at back
int                  mSize [arrays];
logic [dataBits-1:0] mElem [arrays][arrayLength];      // Kept across clear, as in storage
logic [dataBits-1:0] mHeld;                            // Last value on dataOut
logic [31:0]         lfsrState;

// Fibonacci LFSR, taps 32 22 2 1, one step per bit taken
function automatic logic [31:0] randomBits(input int width);
  logic [31:0] value;
  logic        feedback;
  value = '0;
  for (int i = 0; i < width; i++) begin
    feedback  = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
    lfsrState = {lfsrState[30:0], feedback};
    value     = {value[30:0], feedback};
  end
  return value;
endfunction

task automatic modelClear();
  for (int a = 0; a < arrays; a++) begin
    mAllocated[a] = 1'b0;
    mFreed[a]     = 1'b0;
    mSize[a]      = 0;
  end
  mEver = 0;
  mStack.delete();
endtask

// Applies one action to the model and gives the answer seen at done
task automatic predict(input heapPkg::heapAction act, input int a, input int idx,
                       input logic [dataBits-1:0] din,
                       output logic [dataBits-1:0] expData,
                       output heapPkg::heapError expErr);
  logic [dataBits-1:0] answer;
  int                  pick;
  answer = mHeld;
  expErr = heapPkg::errorNone;
  case (act)
    heapPkg::actionReset: begin
      modelClear();
      answer = '0;
    end
    heapPkg::actionAlloc: begin
      if (mStack.size() > 0 || mEver < arrays) begin
        if (mStack.size() > 0) pick = mStack.pop_back();   // Newest freed first
        else begin
          pick  = mEver;
          mEver = mEver + 1;
        end
        mAllocated[pick] = 1'b1;
        mFreed[pick]     = 1'b0;
        mSize[pick]      = 0;
        answer           = dataBits'(pick);
      end else expErr = heapPkg::errorOutOfMemory;
    end
    default: begin
      if (!mAllocated[a]) begin
        expErr = mFreed[a] ? heapPkg::errorFreed : heapPkg::errorNotAllocated;
      end else begin
        case (act)
          heapPkg::actionFree: begin
            mAllocated[a] = 1'b0;
            mFreed[a]     = 1'b1;
            mStack.push_back(a);
            answer = dataBits'(a);
          end
          heapPkg::actionWrite: begin
            mElem[a][idx] = din;
            if (idx >= mSize[a]) mSize[a] = idx + 1;        // Grow to cover index
            answer = din;
          end
          heapPkg::actionRead: begin
            if (idx < mSize[a]) answer = mElem[a][idx];
            else expErr = heapPkg::errorOutOfBounds;
          end
          heapPkg::actionSize: answer = dataBits'(mSize[a]);
          heapPkg::actionPush: begin
            if (mSize[a] == arrayLength) expErr = heapPkg::errorFull;
            else begin
              mElem[a][mSize[a]] = din;
              mSize[a]           = mSize[a] + 1;
              answer             = din;
            end
          end
          heapPkg::actionPop: begin
            if (mSize[a] == 0) expErr = heapPkg::errorEmpty;
            else begin
              mSize[a] = mSize[a] - 1;
              answer   = mElem[a][mSize[a]];                // Last element
            end
          end
          default: begin                                    // Add and AddAfter
            if (idx < mSize[a]) begin
              answer        = (act == heapPkg::actionAdd) ? mElem[a][idx] + din
                                                          : mElem[a][idx];
              mElem[a][idx] = mElem[a][idx] + din;          // Wraps at dataBits
            end else expErr = heapPkg::errorOutOfBounds;
          end
        endcase
      end
    end
  endcase
  if (expErr == heapPkg::errorNone) mHeld = answer;       // dataOut holds on error
  expData = mHeld;
endtask

`endif

//--- test/arrayHeapTb.sv
/* Drives the array heap with directed and LFSR stimulus and checks every
   answer against the reference model. Inputs change 5 ns after the rising
   edge, answers are sampled on the falling edge. */
`default_nettype none

module arrayHeapTb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int arrayBits   = 3;
  localparam int indexBits   = 3;
  localparam int dataBits    = 16;
  localparam int arrays      = 2 ** arrayBits;
  localparam int arrayLength = 2 ** indexBits;
  localparam int drainLimit  = 20;                     // Cycles allowed for answers

  logic                 clock;
  logic                 resetN;
  heapPkg::heapAction   action;
  logic [arrayBits-1:0] array;
  logic [indexBits-1:0] index;
  logic [dataBits-1:0]  dataIn;
  logic [dataBits-1:0]  dataOut;
  heapPkg::heapError    error;
  logic                 done;

  logic [dataBits-1:0]  expData [$];                   // Answers in flight, oldest first
  heapPkg::heapError    expError [$];
  string                expName [$];
  logic [dataBits-1:0]  wantData;
  heapPkg::heapError    wantError;
  string                wantName;
  int                   errorCount;
  int                   timeoutCount;
  int                   checkCount;

  `include "heapRefModel.svh"

  arrayHeap #(
    .arrayBits (arrayBits),
    .indexBits (indexBits),
    .dataBits  (dataBits)
  ) u_dut (
    .clock   (clock),
    .resetN  (resetN),
    .action  (action),
    .array   (array),
    .index   (index),
    .dataIn  (dataIn),
    .dataOut (dataOut),
    .error   (error),
    .done    (done)
  );

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  // ----------------------------------------
  // Checks
  // ----------------------------------------
  doneAfterAction: assert property (@(posedge clock) disable iff (!resetN)
      action != heapPkg::actionIdle |=> done)
    else begin
      errorCount++;
      $display("error doneAfterAction: expected done 1, actual 0");
    end

  noDoneAfterIdle: assert property (@(posedge clock) disable iff (!resetN)
      action == heapPkg::actionIdle |=> !done)
    else begin
      errorCount++;
      $display("error noDoneAfterIdle: expected done 0, actual 1");
    end

  always @(negedge clock) begin
    if (resetN && done) begin
      if (expName.size() == 0) begin
        errorCount++;
        $display("done was raised with no command in flight");
      end else begin
        wantData  = expData.pop_front();
        wantError = expError.pop_front();
        wantName  = expName.pop_front();
        checkCount++;
        assert (error === wantError) else begin
          errorCount++;
          $display("error %s: expected error %0d, actual %0d", wantName, wantError, error);
        end
        assert (dataOut === wantData) else begin
          errorCount++;
          $display("error %s: expected data %h, actual %h", wantName, wantData, dataOut);
        end
      end
    end
  end

  // ----------------------------------------
  // Stimulus helpers
  // ----------------------------------------
  // Called 5 ns after a rising edge, returns 5 ns after the next one
  task automatic issue(input heapPkg::heapAction act, input int a, input int idx,
                       input logic [dataBits-1:0] din, input string name);
    logic [dataBits-1:0] d;
    heapPkg::heapError   e;
    action = act;
    array  = arrayBits'(a);
    index  = indexBits'(idx);
    dataIn = din;
    predict(act, a, idx, din, d, e);
    expData.push_back(d);
    expError.push_back(e);
    expName.push_back(name);
    @(posedge clock);
    #5;
  endtask

  task automatic endRun();
    $display("checked %0d answers, %0d errors, %0d timeouts",
             checkCount, errorCount, timeoutCount);
    if (errorCount == 0 && timeoutCount == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  endtask

  // Idle until every answer in flight has been checked
  task automatic drain();
    int cycles;
    cycles = 0;
    action = heapPkg::actionIdle;
    while (expName.size() != 0 && cycles < drainLimit) begin
      @(posedge clock);
      #5;
      cycles++;
    end
    if (expName.size() != 0) begin
      timeoutCount++;
      $display("timeout: %0d answers still missing after %0d cycles",
               expName.size(), drainLimit);
      endRun();
    end
  endtask

  // ----------------------------------------
  // Test sequence
  // ----------------------------------------
  initial begin
    bit                  written [arrayLength];
    int                  idx;
    logic [dataBits-1:0] val;
    errorCount   = 0;
    timeoutCount = 0;
    checkCount   = 0;
    lfsrState    = 32'heccc;
    mHeld        = '0;
    modelClear();
    resetN = 1'b0;
    action = heapPkg::actionIdle;
    array  = '0;
    index  = '0;
    dataIn = '0;
    repeat (2) @(posedge clock);
    #5 resetN = 1'b1;
    repeat (3) @(posedge clock);                       // No done expected here
    #5;

    issue(heapPkg::actionAlloc, 0, 0, 0, "firstAlloc");
    issue(heapPkg::actionSize, 0, 0, 0, "emptySize");
    drain();

    foreach (written[i]) written[i] = 1'b0;
    for (int i = 0; i < 6; i++) begin
      idx = randomBits(indexBits) % 6;                 // Keeps index 6 and 7 unused
      val = dataBits'(randomBits(dataBits));
      written[idx] = 1'b1;
      issue(heapPkg::actionWrite, 0, idx, val, "randomWrite");
    end
    for (int i = 0; i < arrayLength; i++) begin
      if (written[i]) issue(heapPkg::actionRead, 0, i, 0, "readBack");
    end
    issue(heapPkg::actionSize, 0, 0, 0, "sizeAfterWrites");
    issue(heapPkg::actionRead, 0, 6, 0, "readOutOfBounds");
    issue(heapPkg::actionRead, 0, 7, 0, "readOutOfBounds");
    drain();

    issue(heapPkg::actionAlloc, 0, 0, 0, "secondAlloc");   // Array 1
    for (int i = 0; i <= arrayLength; i++) begin
      issue(heapPkg::actionPush, 1, 0, dataBits'(randomBits(dataBits)), "pushToFull");
    end
    for (int i = 0; i <= arrayLength; i++) begin
      issue(heapPkg::actionPop, 1, 0, 0, "popToEmpty");
    end
    drain();

    issue(heapPkg::actionWrite, 1, 0, 16'hfff0, "addSetup");
    issue(heapPkg::actionAdd, 1, 0, 16'h0020, "addWraps");
    issue(heapPkg::actionAddAfter, 1, 0, 16'h0005, "addAfterOld");
    issue(heapPkg::actionAdd, 1, 0, dataBits'(randomBits(dataBits)), "addRandom");
    issue(heapPkg::actionRead, 1, 0, 0, "addAccumulated");
    issue(heapPkg::actionAdd, 1, 3, 16'h0001, "addOutOfBounds");
    drain();

    for (int i = 2; i <= arrays; i++) begin          // Last one runs out
      issue(heapPkg::actionAlloc, 0, 0, 0, "allocAll");
    end
    issue(heapPkg::actionPush, 3, 0, dataBits'(randomBits(dataBits)), "fillBeforeFree");
    issue(heapPkg::actionFree, 3, 0, 0, "freeArray");
    issue(heapPkg::actionRead, 3, 0, 0, "readFreed");
    issue(heapPkg::actionFree, 3, 0, 0, "doubleFree");
    issue(heapPkg::actionAlloc, 0, 0, 0, "reuseFreed");
    issue(heapPkg::actionSize, 3, 0, 0, "reusedSize");      // Clear drops the pushed element
    issue(heapPkg::actionReset, 0, 0, 0, "resetAction");
    issue(heapPkg::actionRead, 5, 0, 0, "neverAllocated");
    issue(heapPkg::actionFree, 5, 0, 0, "freeNeverAllocated");
    drain();

    // Burst with no idle cycle between commands
    issue(heapPkg::actionAlloc, 0, 0, 0, "burstAlloc");
    issue(heapPkg::actionWrite, 0, 2, dataBits'(randomBits(dataBits)), "burstWrite");
    issue(heapPkg::actionPush, 0, 0, dataBits'(randomBits(dataBits)), "burstPush");
    issue(heapPkg::actionRead, 0, 2, 0, "burstRead");
    issue(heapPkg::actionSize, 0, 0, 0, "burstSize");
    issue(heapPkg::actionAddAfter, 0, 2, dataBits'(randomBits(dataBits)), "burstAddAfter");
    issue(heapPkg::actionPop, 0, 0, 0, "burstPop");
    issue(heapPkg::actionSize, 0, 0, 0, "burstSizeAfterPop");
    issue(heapPkg::actionRead, 0, 2, 0, "burstReadBack");
    drain();

    repeat (2) @(posedge clock);
    endRun();
  end

endmodule

`default_nettype wire

//--- arrayHeap.f
+incdir+test
common/heapPkg.sv
verilog/heapCommandDecoder.sv
arrayBank/arrayBank.sv
verilog/resultCollector.sv
verilog/arrayHeap.sv
test/arrayHeapTb.sv

//--- Bender.yml
package:
  name: arrayHeap

sources:
  - common/heapPkg.sv
  - verilog/heapCommandDecoder.sv
  - arrayBank/arrayBank.sv
  - verilog/resultCollector.sv
  - verilog/arrayHeap.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/arrayHeapTb.sv
